// ==== include/rgbw_defs.svh ====
`ifndef RGBW_DEFS_SVH
`define RGBW_DEFS_SVH

// frame start marker on the spi stream
`define RGBW_SYNC_BYTE 8'h55

// payload bytes after the sync byte
// order is intensity, palette index, red, green, blue, white, mode
`define RGBW_PAYLOAD_LEN 7

// built-in palette entries
// indexed by the low bits of the palette index byte
`define RGBW_PALETTE_SIZE 16

// pwm resolution in bits
// one pwm period is 2**bits clk cycles
`define RGBW_PWM_BITS 8

`endif

// ==== source/rgbw_pkg.sv ====
package rgbw_pkg;

    // steady view of the mode byte, bit 7 clear
    typedef struct packed {
        logic       is_blink;
        logic [5:0] reserved;
        // take colours from the palette table
        logic       palette_sel;
    } rgbw_steady_t;

    // blink view of the mode byte, bit 7 set
    typedef struct packed {
        logic       is_blink;
        // in pwm periods, 0 counts as 1
        logic [6:0] half_period;
    } rgbw_blink_t;

    // one mode byte, decoded by bit 7
    typedef union packed {
        rgbw_steady_t steady;
        rgbw_blink_t  blink;
    } rgbw_mode_u;

endpackage

// ==== source/spi_byte_receiver.sv ====
`timescale 1ns/1ns

module spi_byte_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       cs_n,
    output logic [7:0] rx_byte,
    output logic       rdy,
    output logic       sel
);

    // two-flop synchronizers, bit 1 is the safe one
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_n_sync;
    // delayed sclk for edge detect
    logic       sclk_prev;
    logic       sclk_rise;
    // first seven bits of the byte
    logic [6:0] shift;
    logic [2:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (!reset) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            // chip select idles high
            cs_n_sync <= 2'b11;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            mosi_sync <= {mosi_sync[0], mosi};
            cs_n_sync <= {cs_n_sync[0], cs_n};
            sclk_prev <= sclk_sync[1];
        end
    end

    // mode 0, sample on rising sclk
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sel = ~cs_n_sync[1];

    // msb first, no reset needed on the data path
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            shift <= {shift[5:0], mosi_sync[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            bit_cnt <= 3'd0;
            rx_byte <= 8'h00;
            rdy     <= 1'b0;
        end else begin
            rdy <= 1'b0;
            // deselect realigns to a byte boundary
            if (cs_n_sync[1]) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                // eighth bit completes the byte
                if (bit_cnt == 3'd7) begin
                    rx_byte <= {shift, mosi_sync[1]};
                    rdy     <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/rgbw_data_dispenser.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_data_dispenser (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           rx_byte,
    input  logic                 rdy,
    input  logic                 sel,
    output logic [7:0]           intensity,
    output logic [7:0]           palette_idx,
    output logic [7:0]           red,
    output logic [7:0]           green,
    output logic [7:0]           blue,
    output logic [7:0]           white,
    output rgbw_pkg::rgbw_mode_u mode,
    output logic                 frame_done
);

    import rgbw_pkg::*;

    // byte and strobe latched one clk before use
    logic [7:0] rx_latch;
    logic       rdy_latch;
    // 0 waits for sync, 1..7 are payload slots
    logic [2:0] byte_pos;
    logic       last_byte;
    // payload held here until the frame is complete
    logic [7:0] stage [1:`RGBW_PAYLOAD_LEN-1];

    assign last_byte = (byte_pos == 3'(`RGBW_PAYLOAD_LEN));

    always_ff @(posedge clk) begin
        if (!reset) begin
            rx_latch  <= 8'h00;
            rdy_latch <= 1'b0;
        end else begin
            rx_latch  <= rx_byte;
            rdy_latch <= rdy;
        end
    end

    // byte position tracking
    always_ff @(posedge clk) begin
        if (!reset) begin
            byte_pos <= 3'd0;
        end else if (!sel) begin
            // chip select dropped, any partial frame is lost
            byte_pos <= 3'd0;
        end else if (rdy_latch) begin
            if (byte_pos == 3'd0) begin
                // hunt for the start marker
                if (rx_latch == `RGBW_SYNC_BYTE) begin
                    byte_pos <= 3'd1;
                end
            end else if (last_byte) begin
                byte_pos <= 3'd0;
            end else begin
                byte_pos <= byte_pos + 3'd1;
            end
        end
    end

    // staging slots for intensity through white
    always_ff @(posedge clk) begin
        if (sel && rdy_latch && byte_pos != 3'd0 && !last_byte) begin
            stage[byte_pos] <= rx_latch;
        end
    end

    // output registers change only on a complete frame
    always_ff @(posedge clk) begin
        if (!reset) begin
            intensity   <= 8'h00;
            palette_idx <= 8'h00;
            red         <= 8'h00;
            green       <= 8'h00;
            blue        <= 8'h00;
            white       <= 8'h00;
            mode        <= '0;
            frame_done  <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (sel && rdy_latch && last_byte) begin
                intensity   <= stage[1];
                palette_idx <= stage[2];
                red         <= stage[3];
                green       <= stage[4];
                blue        <= stage[5];
                white       <= stage[6];
                // mode byte goes straight out
                mode        <= rgbw_mode_u'(rx_latch);
                frame_done  <= 1'b1;
            end
        end
    end

endmodule

// ==== source/rgbw_color_gen.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_color_gen (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [7:0]                intensity,
    input  logic [7:0]                palette_idx,
    input  logic [7:0]                red,
    input  logic [7:0]                green,
    input  logic [7:0]                blue,
    input  logic [7:0]                white,
    input  rgbw_pkg::rgbw_mode_u      mode,
    input  logic                      frame_done,
    input  logic                      period_start,
    output logic [`RGBW_PWM_BITS-1:0] level_r,
    output logic [`RGBW_PWM_BITS-1:0] level_g,
    output logic [`RGBW_PWM_BITS-1:0] level_b,
    output logic [`RGBW_PWM_BITS-1:0] level_w
);

    import rgbw_pkg::*;

    localparam int idx_bits = $clog2(`RGBW_PALETTE_SIZE);

    // entries packed as {red, green, blue, white}
    localparam logic [31:0] palette [`RGBW_PALETTE_SIZE] = '{
        32'h00_00_00_00,
        32'hff_00_00_00,
        32'h00_ff_00_00,
        32'h00_00_ff_00,
        32'h00_00_00_ff,
        32'hff_ff_00_00,
        32'h00_ff_ff_00,
        32'hff_00_ff_00,
        32'h40_20_00_ff, // warm white
        32'hff_60_00_00,
        32'h80_00_ff_00,
        32'hff_40_80_00,
        32'h00_80_80_00,
        32'h80_ff_00_00,
        32'h40_a0_ff_00,
        32'hff_ff_ff_ff
    };

    rgbw_blink_t blink_view;
    logic [31:0] entry;
    logic [7:0]  src_r, src_g, src_b, src_w;
    logic [6:0]  half_period;
    logic [6:0]  phase_cnt;
    logic        phase_on;
    logic        phase_wrap;
    // set once the pwm has picked up the new frame
    logic        armed;

    // channel times (intensity + 1), divided by 256
    function automatic logic [`RGBW_PWM_BITS-1:0] scale(input logic [7:0] chan,
                                                      input logic [7:0] gain);
        logic [16:0] prod;
        prod = chan * ({1'b0, gain} + 9'd1);
        return prod[15:8];
    endfunction

    assign blink_view  = mode.blink;
    assign half_period = (blink_view.half_period == 7'd0) ? 7'd1 : blink_view.half_period;
    assign phase_wrap  = (phase_cnt + 7'd1) >= half_period;
    assign entry       = palette[palette_idx[idx_bits-1:0]];

    // palette only in steady view with bit 0 set
    always_comb begin
        if (!blink_view.is_blink && mode.steady.palette_sel) begin
            {src_r, src_g, src_b, src_w} = entry;
        end else begin
            {src_r, src_g, src_b, src_w} = {red, green, blue, white};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            phase_cnt <= 7'd0;
            phase_on  <= 1'b1;
            armed     <= 1'b0;
            level_r   <= '0;
            level_g   <= '0;
            level_b   <= '0;
            level_w   <= '0;
        end else if (frame_done) begin
            // new frame starts in the on phase
            phase_cnt <= 7'd0;
            phase_on  <= 1'b1;
            armed     <= 1'b0;
            level_r   <= scale(src_r, intensity);
            level_g   <= scale(src_g, intensity);
            level_b   <= scale(src_b, intensity);
            level_w   <= scale(src_w, intensity);
        end else if (blink_view.is_blink && period_start) begin
            // first boundary only loads the frame into the pwm
            if (!armed) begin
                armed <= 1'b1;
            end else if (phase_wrap) begin
                phase_cnt <= 7'd0;
                phase_on  <= ~phase_on;
                // leaving the on phase blanks all four
                level_r   <= phase_on ? '0 : scale(src_r, intensity);
                level_g   <= phase_on ? '0 : scale(src_g, intensity);
                level_b   <= phase_on ? '0 : scale(src_b, intensity);
                level_w   <= phase_on ? '0 : scale(src_w, intensity);
            end else begin
                phase_cnt <= phase_cnt + 7'd1;
            end
        end
    end

endmodule

// ==== source/rgbw_pwm.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_pwm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`RGBW_PWM_BITS-1:0] level_r,
    input  logic [`RGBW_PWM_BITS-1:0] level_g,
    input  logic [`RGBW_PWM_BITS-1:0] level_b,
    input  logic [`RGBW_PWM_BITS-1:0] level_w,
    output logic                      pwm_r,
    output logic                      pwm_g,
    output logic                      pwm_b,
    output logic                      pwm_w,
    output logic                      period_start
);

    logic [`RGBW_PWM_BITS-1:0] cnt;
    logic [`RGBW_PWM_BITS-1:0] cnt_next;
    logic [`RGBW_PWM_BITS-1:0] level     [4];
    logic [`RGBW_PWM_BITS-1:0] duty      [4];
    logic [`RGBW_PWM_BITS-1:0] duty_next [4];
    // channel order r, g, b, w
    logic [3:0]                pin;

    assign level[0] = level_r;
    assign level[1] = level_g;
    assign level[2] = level_b;
    assign level[3] = level_w;
    assign cnt_next = cnt + 1'b1;

    // duty for the cycle being entered, new level at count 0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            duty_next[i] = (cnt_next == '0) ? level[i] : duty[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            // first cycle out of reset is count 0
            cnt          <= '1;
            period_start <= 1'b0;
            pin          <= 4'b0000;
            for (int i = 0; i < 4; i++) begin
                duty[i] <= '0;
            end
        end else begin
            cnt          <= cnt_next;
            period_start <= (cnt_next == '0);
            for (int i = 0; i < 4; i++) begin
                duty[i] <= duty_next[i];
                // high for counts 0 .. duty-1
                pin[i]  <= (cnt_next < duty_next[i]);
            end
        end
    end

    assign pwm_r = pin[0];
    assign pwm_g = pin[1];
    assign pwm_b = pin[2];
    assign pwm_w = pin[3];

endmodule

// ==== source/rgbw_led_top.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_led_top (
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic pwm_r,
    output logic pwm_g,
    output logic pwm_b,
    output logic pwm_w,
    output logic period_start
);

    import rgbw_pkg::*;

    // receiver to parser
    logic [7:0] rx_byte;
    logic       rdy;
    logic       sel;
    // parsed frame fields
    logic [7:0] intensity;
    logic [7:0] palette_idx;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [7:0] white;
    rgbw_mode_u mode;
    logic       frame_done;
    // colour generator to pwm
    logic [`RGBW_PWM_BITS-1:0] level_r;
    logic [`RGBW_PWM_BITS-1:0] level_g;
    logic [`RGBW_PWM_BITS-1:0] level_b;
    logic [`RGBW_PWM_BITS-1:0] level_w;

    spi_byte_receiver i_rx (
        .clk     (clk),
        .reset   (reset),
        .sclk    (sclk),
        .mosi    (mosi),
        .cs_n    (cs_n),
        .rx_byte (rx_byte),
        .rdy     (rdy),
        .sel     (sel)
    );

    rgbw_data_dispenser i_parser (
        .clk         (clk),
        .reset       (reset),
        .rx_byte     (rx_byte),
        .rdy         (rdy),
        .sel         (sel),
        .intensity   (intensity),
        .palette_idx (palette_idx),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .white       (white),
        .mode        (mode),
        .frame_done  (frame_done)
    );

    rgbw_color_gen i_color (
        .clk          (clk),
        .reset        (reset),
        .intensity    (intensity),
        .palette_idx  (palette_idx),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .white        (white),
        .mode         (mode),
        .frame_done   (frame_done),
        .period_start (period_start),
        .level_r      (level_r),
        .level_g      (level_g),
        .level_b      (level_b),
        .level_w      (level_w)
    );

    rgbw_pwm i_pwm (
        .clk          (clk),
        .reset        (reset),
        .level_r      (level_r),
        .level_g      (level_g),
        .level_b      (level_b),
        .level_w      (level_w),
        .pwm_r        (pwm_r),
        .pwm_g        (pwm_g),
        .pwm_b        (pwm_b),
        .pwm_w        (pwm_w),
        .period_start (period_start)
    );

endmodule

// ==== sim/rgbw_led_props.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_led_props (
    input logic       clk,
    input logic       reset,
    input logic       frame_done,
    input logic       period_start,
    input logic [3:0] pins
);

    // clks since the last period start
    logic [`RGBW_PWM_BITS:0] since_start;
    // no gap to check before the first start
    logic                    seen_start;

    always_ff @(posedge clk) begin
        if (!reset) begin
            since_start <= '0;
            seen_start  <= 1'b0;
        end else if (period_start) begin
            since_start <= {{`RGBW_PWM_BITS{1'b0}}, 1'b1};
            seen_start  <= 1'b1;
        end else begin
            since_start <= since_start + 1'b1;
        end
    end

    // single clk strobe
    assert property (@(posedge clk) disable iff (!reset) frame_done |=> !frame_done)
        else $error("frame_done high in two consecutive cycles");

    // start exactly when a full period has elapsed
    assert property (@(posedge clk) disable iff (!reset)
        seen_start |-> (period_start == (since_start == {1'b1, {`RGBW_PWM_BITS{1'b0}}})))
        else $error("period_start spacing is not one pwm period");

    // pins settle one clk into reset
    assert property (@(posedge clk) (!reset && !$past(reset)) |-> (pins == 4'b0000))
        else $error("pwm pin high during reset");

endmodule

bind rgbw_data_dispenser rgbw_led_props i_parser_props (
    .clk          (clk),
    .reset        (reset),
    .frame_done   (frame_done),
    .period_start (1'b0),
    .pins         (4'b0000)
);

bind rgbw_pwm rgbw_led_props i_pwm_props (
    .clk          (clk),
    .reset        (reset),
    .frame_done   (1'b0),
    .period_start (period_start),
    .pins         ({pwm_r, pwm_g, pwm_b, pwm_w})
);

// ==== sim/rgbw_led_tb.sv ====
`timescale 1ns/1ns
`include "rgbw_defs.svh"

module rgbw_led_tb;

    import rgbw_pkg::*;

    localparam int max_rows     = 15;
    localparam int period_len   = 1 << `RGBW_PWM_BITS;
    // cs setup then sync plus payload at eight clks per bit then the tail
    localparam int frame_cycles = 4 + 8 * 64 + 12;
    localparam int cycle_limit  = max_rows * (frame_cycles + 6 * period_len) + 2048;

    logic clk;
    logic reset;
    logic sclk;
    logic mosi;
    logic cs_n;
    logic pwm_r;
    logic pwm_g;
    logic pwm_b;
    logic pwm_w;
    logic period_start;

    // stimulus table with payload in wire order
    logic [7:0]  row_payload [max_rows][`RGBW_PAYLOAD_LEN];
    // 0 normal, 1 no sync byte, 2 cut short by cs_n
    int          row_abort   [max_rows];
    int          row_periods [max_rows];
    // expected duties per observed period as {r, g, b, w}
    logic [31:0] row_expect  [max_rows][4];
    int          row_count;

    // reference palette as {red, green, blue, white}
    logic [31:0] ref_palette [`RGBW_PALETTE_SIZE] = '{
        32'h00_00_00_00, 32'hff_00_00_00, 32'h00_ff_00_00, 32'h00_00_ff_00,
        32'h00_00_00_ff, 32'hff_ff_00_00, 32'h00_ff_ff_00, 32'hff_00_ff_00,
        32'h40_20_00_ff, 32'hff_60_00_00, 32'h80_00_ff_00, 32'hff_40_80_00,
        32'h00_80_80_00, 32'h80_ff_00_00, 32'h40_a0_ff_00, 32'hff_ff_ff_ff
    };
    string       chan_names [4] = '{"pwm_r", "pwm_g", "pwm_b", "pwm_w"};

    logic [31:0] lcg_state;
    int          high_cnt [4];
    int          cycle_cnt;
    int          error_cnt;
    int          rows_passed;
    int          rows_failed;

    rgbw_led_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .sclk         (sclk),
        .mosi         (mosi),
        .cs_n         (cs_n),
        .pwm_r        (pwm_r),
        .pwm_g        (pwm_g),
        .pwm_b        (pwm_b),
        .pwm_w        (pwm_w),
        .period_start (period_start)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // watchdog over the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d clk cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] random_byte();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[23:16];
    endfunction

    // duties seen in observed period period_idx after the frame is taken
    function automatic logic [31:0] expected_duties(
        input logic [7:0] intensity,
        input logic [7:0] pal_idx,
        input logic [7:0] r,
        input logic [7:0] g,
        input logic [7:0] b,
        input logic [7:0] w,
        input logic [7:0] mode_byte,
        input int         period_idx
    );
        rgbw_mode_u  mode;
        logic [31:0] chans;
        logic [31:0] duties;
        int          level;
        int          half;
        mode = mode_byte;
        // palette only in steady view with bit 0 set
        if (!mode.steady.is_blink && mode.steady.palette_sel) begin
            chans = ref_palette[int'(pal_idx) % `RGBW_PALETTE_SIZE];
        end else begin
            chans = {r, g, b, w};
        end
        for (int i = 0; i < 4; i++) begin
            level = (int'(chans[8*i +: 8]) * (int'(intensity) + 1)) / 256;
            duties[8*i +: 8] = level[7:0];
        end
        // blink alternates half periods starting on
        if (mode.blink.is_blink) begin
            half = (mode.blink.half_period == 7'd0) ? 1 : int'(mode.blink.half_period);
            if (((period_idx / half) % 2) == 1) begin
                duties = 32'h0;
            end
        end
        return duties;
    endfunction

    task automatic add_row(input int abort_kind, input int periods,
                           input logic [7:0] inten, input logic [7:0] pal,
                           input logic [7:0] r, input logic [7:0] g,
                           input logic [7:0] b, input logic [7:0] w,
                           input logic [7:0] mode_byte);
        row_payload[row_count] = '{inten, pal, r, g, b, w, mode_byte};
        row_abort[row_count]   = abort_kind;
        row_periods[row_count] = periods;
        for (int p = 0; p < 4; p++) begin
            // dropped frame keeps whatever was showing before
            if (abort_kind != 0) begin
                row_expect[row_count][p] = row_expect[row_count - 1][0];
            end else begin
                row_expect[row_count][p] = expected_duties(inten, pal, r, g, b, w,
                                                           mode_byte, p);
            end
        end
        row_count++;
    endtask

    task automatic build_table;
        logic [7:0] rb [6];
        // direct colours at full intensity
        add_row(0, 2, 8'hff, 8'h00, 8'h12, 8'h80, 8'hff, 8'h00, 8'h00);
        add_row(0, 2, 8'hff, 8'h00, 8'h01, 8'hfe, 8'h7f, 8'h40, 8'h00);
        // all channels off at full intensity
        add_row(0, 2, 8'hff, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        // random channels and intensity
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 6; j++) begin
                rb[j] = random_byte();
            end
            add_row(0, 2, rb[0], rb[1], rb[2], rb[3], rb[4], rb[5], 8'h00);
        end
        // palette with reserved mode bits set in the second one
        add_row(0, 2, 8'hff, 8'h08, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01);
        add_row(0, 2, 8'h80, 8'h3e, 8'hff, 8'hff, 8'hff, 8'hff, 8'h7f);
        for (int j = 0; j < 6; j++) begin
            rb[j] = random_byte();
        end
        add_row(0, 2, rb[0], rb[1], rb[2], rb[3], rb[4], rb[5], {1'b0, rb[5][6:1], 1'b1});
        // blink with half period 2
        add_row(0, 4, 8'hff, 8'h00, 8'hc0, 8'h30, 8'h90, 8'h08, 8'h82);
        add_row(0, 2, 8'hff, 8'h00, 8'h20, 8'h40, 8'h60, 8'h80, 8'h00);
        // broken frames followed by a good one
        add_row(1, 2, 8'hff, 8'h00, 8'h11, 8'h22, 8'h33, 8'h44, 8'h00);
        add_row(2, 2, 8'h80, 8'h00, 8'haa, 8'hbb, 8'hcc, 8'hdd, 8'h00);
        add_row(0, 2, 8'hc8, 8'h00, 8'h33, 8'h66, 8'h99, 8'hcc, 8'h00);
        // zero intensity darkens full channels
        add_row(0, 2, 8'h00, 8'h00, 8'hff, 8'hff, 8'hff, 8'hff, 8'h00);
    endtask

    // spi mode 0 with msb first and four clks per sclk half
    task automatic send_byte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            sclk <= 1'b0;
            mosi <= value[i];
            repeat (4) @(posedge clk);
            sclk <= 1'b1;
            repeat (4) @(posedge clk);
        end
    endtask

    task automatic send_frame(input int row);
        int payload_bytes;
        payload_bytes = (row_abort[row] == 2) ? 3 : `RGBW_PAYLOAD_LEN;
        @(posedge clk);
        cs_n <= 1'b0;
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        send_byte((row_abort[row] == 1) ? 8'haa : `RGBW_SYNC_BYTE);
        for (int k = 0; k < payload_bytes; k++) begin
            send_byte(row_payload[row][k]);
        end
        sclk <= 1'b0;
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    // returns at the falling edge inside the next period_start cycle
    task automatic wait_period_start;
        do begin
            @(negedge clk);
        end while (!period_start);
    endtask

    // count high cycles from this period_start to the next
    task automatic measure_period;
        for (int i = 0; i < 4; i++) begin
            high_cnt[i] = 0;
        end
        do begin
            if (pwm_r) begin
                high_cnt[0]++;
            end
            if (pwm_g) begin
                high_cnt[1]++;
            end
            if (pwm_b) begin
                high_cnt[2]++;
            end
            if (pwm_w) begin
                high_cnt[3]++;
            end
            @(negedge clk);
        end while (!period_start);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            error_cnt++;
        end
    endtask

    initial begin
        logic [31:0] exp_word;
        int          errors_before;
        reset       = 1'b0;
        sclk        = 1'b0;
        mosi        = 1'b0;
        cs_n        = 1'b1;
        cycle_cnt   = 0;
        error_cnt   = 0;
        rows_passed = 0;
        rows_failed = 0;
        row_count   = 0;
        lcg_state   = 32'h45c;
        build_table();

        repeat (4) @(posedge clk);
        reset <= 1'b1;
        // frames start right after a period boundary
        wait_period_start();

        for (int row = 0; row < row_count; row++) begin
            errors_before = error_cnt;
            send_frame(row);
            // first boundary picks up the frame so measuring starts at the second
            wait_period_start();
            wait_period_start();
            for (int p = 0; p < row_periods[row]; p++) begin
                measure_period();
                exp_word = row_expect[row][p];
                for (int i = 0; i < 4; i++) begin
                    check_value($sformatf("%s (row %0d, period %0d)", chan_names[i], row, p),
                                int'(exp_word[8*(3-i) +: 8]), high_cnt[i]);
                end
            end
            if (error_cnt == errors_before) begin
                rows_passed++;
                $display("row %0d: ok", row);
            end else begin
                rows_failed++;
                $display("row %0d: %0d mismatches", row, error_cnt - errors_before);
            end
        end

        $display("rows passed %0d, rows failed %0d, mismatches %0d",
                 rows_passed, rows_failed, error_cnt);
        if (rows_failed == 0 && error_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
source/rgbw_pkg.sv
source/spi_byte_receiver.sv
source/rgbw_data_dispenser.sv
source/rgbw_color_gen.sv
source/rgbw_pwm.sv
source/rgbw_led_top.sv
sim/rgbw_led_props.sv
sim/rgbw_led_tb.sv

// ==== Makefile ====
# Verilator build and run for the RGBW LED driver testbench

VERILATOR ?= verilator
TOP       ?= rgbw_led_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
